//--- hw/core_pkg.sv
// shared types of the RV32I core: opcodes, ALU operations, instruction
// layouts, decoded fields and the memory port
`include "core_defines.svh"

package core_pkg;

    // major opcodes; ILLEGAL marks anything the core does not implement
    typedef enum logic [6:0] {
        OP      = 7'b0110011,
        OPIMM   = 7'b0010011,
        LOAD    = 7'b0000011,
        STORE   = 7'b0100011,
        BRANCH  = 7'b1100011,
        LUI     = 7'b0110111,
        AUIPC   = 7'b0010111,
        JAL     = 7'b1101111,
        JALR    = 7'b1100111,
        ILLEGAL = 7'b0000000
    } opcode_e;

    // ten arithmetic operations followed by the six branch compares
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one fetched word, viewed in each of the six encodings
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef struct packed {
        opcode_e                opcode;
        logic [`REG_SEL_W-1:0]  rd;
        logic [`REG_SEL_W-1:0]  rs1;
        logic [`REG_SEL_W-1:0]  rs2;
        alu_op_e                alu_op;
        logic                   use_imm;
        logic [`DATA_W-1:0]     imm;
    } decoded_t;

    // core to memory, held stable while req is high
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] wr_data;
        logic               we;
        logic               req;
    } mem_req_t;

    // memory to core
    typedef struct packed {
        logic [`DATA_W-1:0] rd_data;
        logic               ack;
    } mem_rsp_t;

endpackage

//--- hw/core_sequencer.sv
// fetch/execute/memory sequencer: PC, instruction register, four-phase
// memory handshake, write-back selection, output word and halt
`timescale 1ns/1ps
`include "core_defines.svh"

module core_sequencer import core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ena,
    output mem_req_t              mem_req,
    input  mem_rsp_t              mem_rsp,
    output instr_u                instr,
    input  decoded_t              dec,
    input  logic [`DATA_W-1:0]    rs1_data,
    input  logic [`DATA_W-1:0]    rs2_data,
    input  logic [`DATA_W-1:0]    alu_result,
    input  logic                  alu_taken,
    output logic                  rd_we,
    output logic [`REG_SEL_W-1:0] rd_sel,
    output logic [`DATA_W-1:0]    rd_data,
    output logic [`DATA_W-1:0]    out_data,
    output logic                  out_valid,
    output logic                  halt
);

    typedef enum logic [1:0] {FETCH, EXEC, MEM, RELEASE} state_e;

    state_e             state;
    logic [`ADDR_W-1:0] pc;
    logic               req_q;
    logic               we_q;
    logic [`ADDR_W-1:0] addr_q;
    logic [`DATA_W-1:0] wdata_q;

    logic [`ADDR_W-1:0] pc_next4;
    logic [`ADDR_W-1:0] pc_imm;
    logic [`ADDR_W-1:0] ea;
    logic [`ADDR_W-1:0] next_pc;
    logic               fetch_start;
    logic               fetch_done;
    logic               exec_go;
    logic               mem_start;
    logic               mem_done;
    logic               is_store;
    logic               out_hit;
    logic               halt_hit;
    logic               mem_access;
    logic               halt_now;
    logic               writes_rd;

    // a new request only goes out once the previous ack has dropped
    assign fetch_start = state == FETCH && !req_q && !mem_rsp.ack && ena && !halt;
    assign fetch_done  = state == FETCH && req_q && mem_rsp.ack;
    assign exec_go     = state == EXEC && ena;
    assign mem_start   = state == MEM && !req_q && !mem_rsp.ack && ena;
    assign mem_done    = state == MEM && req_q && mem_rsp.ack;

    // effective address, also the jalr target base
    assign ea       = rs1_data + dec.imm;
    assign pc_next4 = pc + 32'd4;
    assign pc_imm   = pc + dec.imm;

    assign is_store   = dec.opcode == STORE;
    assign out_hit    = ea == `OUT_ADDR;
    assign halt_hit   = ea == `HALT_ADDR;
    assign mem_access = dec.opcode == LOAD || (is_store && !out_hit && !halt_hit);
    assign halt_now   = dec.opcode == ILLEGAL || (is_store && halt_hit);
    assign writes_rd  = dec.opcode inside {OP, OPIMM, LUI, AUIPC, JAL, JALR};

    always_comb begin
        case (dec.opcode)
            BRANCH:  next_pc = alu_taken ? pc_imm : pc_next4;
            JAL:     next_pc = pc_imm;
            JALR:    next_pc = {ea[`ADDR_W-1:1], 1'b0};
            default: next_pc = pc_next4;
        endcase
    end

    always_comb begin
        case (dec.opcode)
            LUI:       rd_data = dec.imm;
            AUIPC:     rd_data = pc_imm;
            JAL, JALR: rd_data = pc_next4;
            LOAD:      rd_data = mem_rsp.rd_data;
            default:   rd_data = alu_result;
        endcase
    end

    // load data is written on the ack cycle of the data access
    assign rd_we  = (exec_go && writes_rd) || (mem_done && !we_q);
    assign rd_sel = dec.rd;

    assign out_data  = rs2_data;
    assign out_valid = exec_go && is_store && out_hit;

    assign mem_req = '{addr: addr_q, wr_data: wdata_q, we: we_q, req: req_q};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= FETCH;
            pc    <= `RESET_PC;
            req_q <= 1'b0;
            we_q  <= 1'b0;
            halt  <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (fetch_start) begin
                        req_q <= 1'b1;
                        we_q  <= 1'b0;
                    end else if (fetch_done) begin
                        req_q <= 1'b0;
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    if (exec_go) begin
                        if (halt_now) begin
                            // FETCH stays idle from here on
                            halt  <= 1'b1;
                            state <= FETCH;
                        end else begin
                            pc <= next_pc;
                            if (mem_access) begin
                                we_q  <= is_store;
                                state <= MEM;
                            end else begin
                                state <= FETCH;
                            end
                        end
                    end
                end
                MEM: begin
                    if (mem_start) begin
                        req_q <= 1'b1;
                    end else if (mem_done) begin
                        req_q <= 1'b0;
                        state <= RELEASE;
                    end
                end
                default: begin
                    // wait for the memory to close the handshake
                    if (!mem_rsp.ack) begin
                        state <= FETCH;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_start) begin
            addr_q <= pc;
        end
        if (fetch_done) begin
            instr <= mem_rsp.rd_data;
        end
        if (exec_go && mem_access) begin
            addr_q  <= ea;
            wdata_q <= rs2_data;
        end
    end

endmodule

//--- hw/core_top.sv
// RV32I multi-cycle core, sequencer with decoder, register file and ALU
`timescale 1ns/1ps
`include "core_defines.svh"

module core_top import core_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               ena,
    output mem_req_t           mem_req,
    input  mem_rsp_t           mem_rsp,
    output logic [`DATA_W-1:0] out_data,
    output logic               out_valid,
    output logic               halt
);

    instr_u                instr;
    decoded_t              dec;
    logic [`DATA_W-1:0]    rs1_data;
    logic [`DATA_W-1:0]    rs2_data;
    logic [`DATA_W-1:0]    alu_result;
    logic                  alu_taken;
    logic                  rd_we;
    logic [`REG_SEL_W-1:0] rd_sel;
    logic [`DATA_W-1:0]    rd_data;

    core_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .ena        (ena),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .instr      (instr),
        .dec        (dec),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .alu_taken  (alu_taken),
        .rd_we      (rd_we),
        .rd_sel     (rd_sel),
        .rd_data    (rd_data),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .halt       (halt)
    );

    instr_decoder u_dec (
        .instr (instr),
        .dec   (dec)
    );

    reg_file u_rf (
        .clk      (clk),
        .rst      (rst),
        .rs1_sel  (dec.rs1),
        .rs2_sel  (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rd_we),
        .rd_sel   (rd_sel),
        .rd_data  (rd_data)
    );

    int_alu u_alu (
        .op      (dec.alu_op),
        .a       (rs1_data),
        .b       (rs2_data),
        .imm     (dec.imm),
        .use_imm (dec.use_imm),
        .result  (alu_result),
        .taken   (alu_taken)
    );

endmodule

//--- hw/instr_decoder.sv
// instruction decoder: register selects, ALU operation and the
// sign-extended immediate of the current instruction word
`timescale 1ns/1ps
`include "core_defines.svh"

module instr_decoder import core_pkg::*; (
    input  instr_u   instr,
    output decoded_t dec
);

    logic [`DATA_W-1:0] imm_i;
    logic [`DATA_W-1:0] imm_s;
    logic [`DATA_W-1:0] imm_b;
    logic [`DATA_W-1:0] imm_u;
    logic [`DATA_W-1:0] imm_j;

    // shared by OP and OPIMM; alt picks sub and sra
    function automatic alu_op_e arith_op(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic alu_op_e branch_op(input logic [2:0] funct3);
        case (funct3)
            3'b001:  return ALU_BNE;
            3'b100:  return ALU_BLT;
            3'b101:  return ALU_BGE;
            3'b110:  return ALU_BLTU;
            3'b111:  return ALU_BGEU;
            default: return ALU_BEQ;
        endcase
    endfunction

    assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
    assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign imm_b = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                    instr.b.imm10_5, instr.b.imm4_1, 1'b0};
    assign imm_u = {instr.u.imm, 12'b0};
    assign imm_j = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                    instr.j.imm11, instr.j.imm10_1, 1'b0};

    always_comb begin
        // register fields sit in the same place in every layout
        dec.rd      = instr.r.rd;
        dec.rs1     = instr.r.rs1;
        dec.rs2     = instr.r.rs2;
        dec.opcode  = ILLEGAL;
        dec.alu_op  = ALU_ADD;
        dec.use_imm = 1'b0;
        dec.imm     = '0;
        case (instr.r.opcode)
            OP: begin
                dec.opcode = OP;
                dec.alu_op = arith_op(instr.r.funct3, instr.r.funct7[5]);
            end
            OPIMM: begin
                dec.opcode  = OPIMM;
                // only srai carries the alternate bit in its immediate
                dec.alu_op  = arith_op(instr.r.funct3,
                                       instr.r.funct3 == 3'b101 && instr.r.funct7[5]);
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
            end
            LOAD: begin
                dec.opcode  = LOAD;
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
            end
            JALR: begin
                dec.opcode  = JALR;
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
            end
            STORE: begin
                dec.opcode = STORE;
                dec.imm    = imm_s;
            end
            BRANCH: begin
                dec.opcode = BRANCH;
                dec.alu_op = branch_op(instr.b.funct3);
                dec.imm    = imm_b;
            end
            LUI: begin
                dec.opcode = LUI;
                dec.imm    = imm_u;
            end
            AUIPC: begin
                dec.opcode = AUIPC;
                dec.imm    = imm_u;
            end
            JAL: begin
                dec.opcode = JAL;
                dec.imm    = imm_j;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- hw/int_alu.sv
// integer ALU: arithmetic, logic and shifts, plus the branch compare
`timescale 1ns/1ps
`include "core_defines.svh"

module int_alu import core_pkg::*; (
    input  alu_op_e            op,
    input  logic [`DATA_W-1:0] a,
    input  logic [`DATA_W-1:0] b,
    input  logic [`DATA_W-1:0] imm,
    input  logic               use_imm,
    output logic [`DATA_W-1:0] result,
    output logic               taken
);

    logic [`DATA_W-1:0] opnd;
    logic [4:0]         shamt;
    logic               lt_s;
    logic               lt_u;
    logic               br_eq;
    logic               br_lt_s;
    logic               br_lt_u;

    assign opnd  = use_imm ? imm : b;
    assign shamt = opnd[4:0];

    // set-less-than compares against the selected operand
    assign lt_s = $signed(a) < $signed(opnd);
    assign lt_u = a < opnd;

    // branches always compare the two registers
    assign br_eq   = a == b;
    assign br_lt_s = $signed(a) < $signed(b);
    assign br_lt_u = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + opnd;
            ALU_SUB:  result = a - opnd;
            ALU_AND:  result = a & opnd;
            ALU_OR:   result = a | opnd;
            ALU_XOR:  result = a ^ opnd;
            ALU_SLT:  result = {{(`DATA_W-1){1'b0}}, lt_s};
            ALU_SLTU: result = {{(`DATA_W-1){1'b0}}, lt_u};
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            default:  result = '0;
        endcase
    end

    always_comb begin
        case (op)
            ALU_BEQ:  taken = br_eq;
            ALU_BNE:  taken = !br_eq;
            ALU_BLT:  taken = br_lt_s;
            ALU_BGE:  taken = !br_lt_s;
            ALU_BLTU: taken = br_lt_u;
            ALU_BGEU: taken = !br_lt_u;
            default:  taken = 1'b0;
        endcase
    end

endmodule

//--- hw/reg_file.sv
// integer register file, two asynchronous read ports and one write port
`timescale 1ns/1ps
`include "core_defines.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`REG_SEL_W-1:0] rs1_sel,
    input  logic [`REG_SEL_W-1:0] rs2_sel,
    output logic [`DATA_W-1:0]    rs1_data,
    output logic [`DATA_W-1:0]    rs2_data,
    input  logic                  we,
    input  logic [`REG_SEL_W-1:0] rd_sel,
    input  logic [`DATA_W-1:0]    rd_data
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];

    assign rs1_data = regs[rs1_sel];
    assign rs2_data = regs[rs2_sel];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_sel != '0) begin
            // x0 is never written, so it reads back as zero
            regs[rd_sel] <= rd_data;
        end
    end

endmodule

//--- include/core_defines.svh
// core sizing constants, reset vector and the memory-mapped I/O addresses
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath widths
`define ADDR_W 32
`define DATA_W 32

// register file geometry
`define NUM_REGS 32
`define REG_SEL_W 5

// first instruction fetched after reset
`define RESET_PC 32'd128

// stores to these addresses never reach memory
`define OUT_ADDR 32'd1000000
`define HALT_ADDR 32'd1000004

`endif

//--- list.f
+incdir+include
hw/core_pkg.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/int_alu.sv
hw/core_sequencer.sv
hw/core_top.sv
sim/tb_core.sv

//--- run.sh
#!/usr/bin/env bash
# builds the RV32I core and its testbench with Verilator, then runs the simulation
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary -f list.f --top-module tb_core -j 0; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_core)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" <<< "$output"; then
    exit 0
fi

exit 1

//--- sim/tb_core.sv
// testbench for the RV32I core with a four-phase memory slave, program loader,
// reference ISA model and output checker
`timescale 1ns/1ps
`include "core_defines.svh"

module tb_core import core_pkg::*; ();

    localparam int MEM_WORDS  = 1024;
    // a few hundred instructions at about 15 cycles each and a wide margin
    localparam int MAX_CYCLES = 20000;

    // funct3 codes of the arithmetic and branch groups
    localparam int F_ADD  = 0;
    localparam int F_SLL  = 1;
    localparam int F_SLT  = 2;
    localparam int F_SLTU = 3;
    localparam int F_XOR  = 4;
    localparam int F_SR   = 5;
    localparam int F_OR   = 6;
    localparam int F_AND  = 7;
    localparam int B_NE   = 1;
    localparam int B_LT   = 4;
    localparam int B_GE   = 5;
    localparam int B_LTU  = 6;
    localparam int B_GEU  = 7;

    logic        clk;
    logic        rst;
    logic        ena;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;
    logic [31:0] out_data;
    logic        out_valid;
    logic        halt;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] ref_mem [MEM_WORDS];
    logic [31:0] prog [$];
    logic [31:0] exp_q [$];

    int seed;
    int ack_wait;
    int stretch;
    int cycles;
    int errors;
    int checks;
    int tests;
    bit stall_en;

    core_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .ena       (ena),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .out_data  (out_data),
        .out_valid (out_valid),
        .halt      (halt)
    );

    always #5 clk = !clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // one instruction encoder per format
    task automatic reg_op(input int f3, input int alt, input int rd, input int rs1, input int rs2);
        prog.push_back({1'b0, alt[0], 5'd0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP});
    endtask

    task automatic imm_op(input int f3, input int rd, input int rs1, input int imm);
        prog.push_back({imm[11:0], rs1[4:0], f3[2:0], rd[4:0], OPIMM});
    endtask

    task automatic load_word(input int rd, input int rs1, input int imm);
        prog.push_back({imm[11:0], rs1[4:0], 3'd2, rd[4:0], LOAD});
    endtask

    task automatic store_word(input int rs2, input int rs1, input int imm);
        prog.push_back({imm[11:5], rs2[4:0], rs1[4:0], 3'd2, imm[4:0], STORE});
    endtask

    task automatic branch_to(input int f3, input int rs1, input int rs2, input int off);
        prog.push_back({off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                        BRANCH});
    endtask

    task automatic upper_imm(input opcode_e op, input int rd, input int imm);
        prog.push_back({imm[19:0], rd[4:0], op});
    endtask

    task automatic jal_to(input int rd, input int off);
        prog.push_back({off[20], off[10:1], off[11], off[19:12], rd[4:0], JAL});
    endtask

    task automatic indirect_jump(input int rd, input int rs1, input int imm);
        prog.push_back({imm[11:0], rs1[4:0], 3'd0, rd[4:0], JALR});
    endtask

    // x31 holds the output address for the whole program
    task automatic start_program();
        prog.delete();
        upper_imm(LUI, 31, 'hF4);
        imm_op(F_ADD, 31, 31, 'h240);
    endtask

    task automatic out(input int rs);
        store_word(rs, 31, 0);
    endtask

    task automatic stop_core();
        store_word(0, 31, 4);
    endtask

    task automatic alu_program();
        start_program();
        imm_op(F_ADD, 1, 0, -7);
        upper_imm(LUI, 2, 'h12345);
        imm_op(F_ADD, 2, 2, 'h678);
        imm_op(F_ADD, 4, 0, 5);
        reg_op(F_ADD, 0, 3, 1, 2);
        out(3);
        reg_op(F_ADD, 1, 3, 1, 2);
        out(3);
        reg_op(F_AND, 0, 3, 1, 2);
        out(3);
        reg_op(F_OR, 0, 3, 1, 2);
        out(3);
        reg_op(F_XOR, 0, 3, 1, 2);
        out(3);
        imm_op(F_XOR, 3, 2, -1);
        out(3);
        imm_op(F_AND, 3, 1, 'h0F0);
        out(3);
        reg_op(F_SLL, 0, 3, 2, 4);
        out(3);
        reg_op(F_SR, 0, 3, 1, 4);
        out(3);
        reg_op(F_SR, 1, 3, 1, 4);
        out(3);
        imm_op(F_SLL, 3, 2, 31);
        out(3);
        // srai by 3
        imm_op(F_SR, 3, 1, 'h403);
        out(3);
        reg_op(F_SLT, 0, 3, 1, 2);
        out(3);
        reg_op(F_SLTU, 0, 3, 1, 2);
        out(3);
        imm_op(F_SLT, 3, 1, -8);
        out(3);
        imm_op(F_SLTU, 3, 2, -1);
        out(3);
        stop_core();
    endtask

    task automatic memory_program();
        start_program();
        imm_op(F_ADD, 5, 0, 'h300);
        imm_op(F_ADD, 6, 0, 100);
        upper_imm(LUI, 7, 'hABCDE);
        imm_op(F_ADD, 8, 0, -3);
        store_word(6, 5, 0);
        store_word(7, 5, 4);
        store_word(8, 5, 12);
        store_word(7, 5, -4);
        load_word(9, 5, 0);
        load_word(10, 5, 4);
        load_word(11, 5, 12);
        reg_op(F_ADD, 0, 12, 9, 10);
        reg_op(F_ADD, 0, 12, 12, 11);
        out(12);
        load_word(13, 5, -4);
        out(13);
        stop_core();
    endtask

    task automatic branch_program();
        start_program();
        imm_op(F_ADD, 1, 0, 5);
        imm_op(F_ADD, 2, 0, 0);
        // countdown loop sums 5..1
        reg_op(F_ADD, 0, 2, 2, 1);
        imm_op(F_ADD, 1, 1, -1);
        branch_to(B_NE, 1, 0, -8);
        out(2);
        imm_op(F_ADD, 3, 0, -1);
        imm_op(F_ADD, 4, 0, 1);
        imm_op(F_ADD, 5, 0, 0);
        branch_to(B_LT, 3, 4, 8);
        imm_op(F_ADD, 5, 5, 1);
        branch_to(B_LTU, 3, 4, 8);
        imm_op(F_ADD, 5, 5, 2);
        branch_to(B_GE, 4, 3, 8);
        imm_op(F_ADD, 5, 5, 4);
        branch_to(B_GEU, 4, 3, 8);
        imm_op(F_ADD, 5, 5, 8);
        out(5);
        jal_to(1, 16);
        out(6);
        out(1);
        stop_core();
        // subroutine keeps its link value in memory
        imm_op(F_ADD, 6, 0, 77);
        store_word(1, 0, 'h300);
        indirect_jump(0, 1, 0);
    endtask

    task automatic auipc_program();
        start_program();
        upper_imm(AUIPC, 3, 'h1);
        out(3);
        upper_imm(AUIPC, 3, 0);
        out(3);
        imm_op(F_ADD, 0, 0, 55);
        reg_op(F_ADD, 0, 0, 3, 3);
        out(0);
        reg_op(F_ADD, 0, 7, 0, 0);
        out(7);
        // an all-zero word is not a valid opcode and halts the core
        prog.push_back(32'h0);
    endtask

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (i * 32'h9E3779B1) ^ 32'h0BADF00D;
        end
        foreach (prog[k]) begin
            mem[(`RESET_PC >> 2) + k] = prog[k];
        end
    endtask

    // ISA model that runs the program on a copy of memory and collects the output words
    function automatic void run_reference();
        logic [31:0] x [32];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] ea;
        logic [31:0] res;
        logic [31:0] nxt;
        logic        cond;
        logic        wr;
        bit          stop;
        int          steps;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = mem[i];
        end
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        exp_q.delete();
        pc = `RESET_PC;
        stop = 1'b0;
        steps = 0;
        while (!stop && steps < 2000) begin
            ins = ref_mem[pc[11:2]];
            a = x[ins[19:15]];
            b = x[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            nxt = pc + 32'd4;
            wr = 1'b1;
            res = '0;
            case (ins[6:0])
                OP, OPIMM: begin
                    // bit 5 of the opcode separates register from immediate forms
                    if (!ins[5]) begin
                        b = imm_i;
                    end
                    case (ins[14:12])
                        3'd0: res = (ins[5] && ins[30]) ? a - b : a + b;
                        3'd1: res = a << b[4:0];
                        3'd2: res = {31'd0, $signed(a) < $signed(b)};
                        3'd3: res = {31'd0, a < b};
                        3'd4: res = a ^ b;
                        3'd5: begin
                            if (ins[30]) begin
                                res = $signed(a) >>> b[4:0];
                            end else begin
                                res = a >> b[4:0];
                            end
                        end
                        3'd6: res = a | b;
                        default: res = a & b;
                    endcase
                end
                LOAD: begin
                    ea = a + imm_i;
                    res = ref_mem[ea[11:2]];
                end
                STORE: begin
                    wr = 1'b0;
                    ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    if (ea == `OUT_ADDR) begin
                        exp_q.push_back(b);
                    end else if (ea == `HALT_ADDR) begin
                        stop = 1'b1;
                    end else begin
                        ref_mem[ea[11:2]] = b;
                    end
                end
                BRANCH: begin
                    wr = 1'b0;
                    case (ins[14:12])
                        3'd0: cond = a == b;
                        3'd1: cond = a != b;
                        3'd4: cond = $signed(a) < $signed(b);
                        3'd5: cond = $signed(a) >= $signed(b);
                        3'd6: cond = a < b;
                        default: cond = a >= b;
                    endcase
                    if (cond) begin
                        nxt = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                LUI: res = {ins[31:12], 12'd0};
                AUIPC: res = pc + {ins[31:12], 12'd0};
                JAL: begin
                    res = nxt;
                    nxt = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                JALR: begin
                    res = nxt;
                    nxt = (a + imm_i) & ~32'd1;
                end
                default: begin
                    wr = 1'b0;
                    stop = 1'b1;
                end
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                x[ins[11:7]] = res;
            end
            pc = nxt;
            steps++;
        end
    endfunction

    task automatic reset_core();
        @(negedge clk);
        rst <= 1'b0;
        repeat (10) @(negedge clk);
        rst <= 1'b1;
    endtask

    task automatic run_program(input string name, input bit stall);
        int e0;
        int c0;
        e0 = errors;
        c0 = checks;
        load_program();
        run_reference();
        stall_en = stall;
        reset_core();
        while (!halt) begin
            @(posedge clk);
        end
        // a halted core stays halted and off the bus
        repeat (20) begin
            @(posedge clk);
            check("halt", {31'd0, halt}, 32'd1);
            check("mem_req.req", {31'd0, mem_req.req}, 32'd0);
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected output words never appeared", exp_q.size());
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            check($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
        end
        tests++;
        $display("test %s: %0d checks, %0d errors", name, checks - c0, errors - e0);
    endtask

    // memory slave and ena stretches are both driven on the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            mem_rsp.ack = 1'b0;
            ack_wait = -1;
            ena = 1'b1;
            stretch = 0;
        end else begin
            if (!stall_en) begin
                ena = 1'b1;
            end else if (stretch == 0) begin
                ena = !ena;
                stretch = ($random(seed) & 7) + 1;
            end else begin
                stretch--;
            end
            if (mem_rsp.ack) begin
                if (!mem_req.req) begin
                    mem_rsp.ack = 1'b0;
                end
            end else if (mem_req.req) begin
                if (ack_wait < 0) begin
                    ack_wait = $random(seed) & 3;
                end
                if (ack_wait == 0) begin
                    if (mem_req.we) begin
                        mem[mem_req.addr[11:2]] = mem_req.wr_data;
                    end else begin
                        mem_rsp.rd_data = mem[mem_req.addr[11:2]];
                    end
                    mem_rsp.ack = 1'b1;
                    ack_wait = -1;
                end else begin
                    ack_wait--;
                end
            end
        end
    end

    // each output pulse is matched against the next reference word
    always @(posedge clk) begin
        if (rst && out_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected output word %h at %0t", out_data, $time);
            end else begin
                check("out_data", out_data, exp_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the core did not finish within %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rst <= 1'b0;
        ena = 1'b1;
        mem_rsp = '0;
        seed = 54001;
        stall_en = 1'b0;
        cycles = 0;
        errors = 0;
        checks = 0;
        tests = 0;
        alu_program();
        run_program("alu", 1'b0);
        memory_program();
        run_program("load/store", 1'b0);
        branch_program();
        run_program("branch/jump", 1'b0);
        auipc_program();
        run_program("auipc/x0", 1'b0);
        memory_program();
        run_program("load/store with ena stalls", 1'b1);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
